/* approx_div_array.sv */
`timescale 1ns/100ps
`include "approx_div_consts.svh"

module approx_div_array #(
  parameter int APPROX_ROWS = `DIV_APPROX_ROWS
) (
  input  approx_div_pkg::dividend_t  dividend,
  input  approx_div_pkg::divisor_t   divisor,
  output approx_div_pkg::quotient_t  quotient,
  output approx_div_pkg::remainder_t remainder
);

  localparam int N_W = `DIV_N_W;
  localparam int D_W = `DIV_D_W;

  // Per row: minuend bits, borrow chain, restored partial remainder
  wire [D_W-1:0] row_min  [D_W];
  wire [D_W-1:0] row_bin  [D_W];
  wire [D_W-1:0] row_bout [D_W];
  wire [D_W-1:0] row_rem  [D_W];

  // Bit shifted out of the row above, and the quotient bit of each row
  wire [D_W-1:0] row_spill;
  wire [D_W-1:0] q_bit;

  genvar row;
  genvar col;

  // ############################################################
  // Cell grid, row D_W-1 gives the quotient MSB
  // ############################################################

  generate
    for (row = 0; row < D_W; row++) begin : g_row

      if (row == D_W - 1) begin : g_top
        // Top row sees dividend bits 14 down to 7, bit 15 is its spill
        assign row_min[row]   = dividend[N_W-2 -: D_W];
        assign row_spill[row] = dividend[N_W-1];
      end else begin : g_lower
        // Shift the row above left and bring in the next dividend bit
        assign row_min[row]   = {row_rem[row+1][D_W-2:0], dividend[row]};
        assign row_spill[row] = row_rem[row+1][D_W-1];
      end

      // Subtraction fits if a bit spilled out or no borrow is left over
      assign q_bit[row] = row_spill[row] | ~row_bout[row][D_W-1];

      for (col = 0; col < D_W; col++) begin : g_cell

        if (col == 0) begin : g_lsb
          assign row_bin[row][col] = 1'b0;
        end else begin : g_chain
          assign row_bin[row][col] = row_bout[row][col-1];
        end

        if (row < APPROX_ROWS) begin : g_approx
          // Borrow-out is just the minuend bit, difference is tied to zero
          assign row_bout[row][col] = row_min[row][col];
          assign row_rem[row][col]  = q_bit[row] ? 1'b0 : row_min[row][col];
        end else begin : g_exact
          wire diff;

          // Full subtractor followed by the restore mux
          assign diff = row_min[row][col] ^ divisor[col] ^ row_bin[row][col];
          assign row_bout[row][col] =
            (~row_min[row][col] & divisor[col]) |
            (~(row_min[row][col] ^ divisor[col]) & row_bin[row][col]);
          assign row_rem[row][col] = q_bit[row] ? diff : row_min[row][col];
        end

      end
    end
  endgenerate

  // ############################################################
  // Results
  // ############################################################

  assign quotient  = q_bit;
  assign remainder = row_rem[0];

endmodule

/* approx_div_consts.svh */
`ifndef APPROX_DIV_CONSTS_SVH
`define APPROX_DIV_CONSTS_SVH

// ############################################################
// Operand widths
// ############################################################

// Dividend is twice the divisor width
`define DIV_N_W 16

// Divisor, quotient and remainder share one width
`define DIV_D_W 8

// ############################################################
// Approximation depth
// ############################################################

// Number of low quotient rows built from approximate cells,
// valid range is 0 (fully exact) up to DIV_D_W
`define DIV_APPROX_ROWS 6

`endif

/* approx_div_pkg.sv */
`include "approx_div_consts.svh"

package approx_div_pkg;

  // ############################################################
  // Operand and result words
  // ############################################################

  // Unsigned dividend
  typedef logic [`DIV_N_W-1:0] dividend_t;

  // Unsigned divisor
  typedef logic [`DIV_D_W-1:0] divisor_t;

  // Quotient of the array, all ones on a zero divisor
  typedef logic [`DIV_D_W-1:0] quotient_t;

  // Remainder taken from the lowest row
  typedef logic [`DIV_D_W-1:0] remainder_t;

endpackage

/* approx_div_unit.f */
+incdir+.
approx_div_pkg.sv
div_operand_capture.sv
approx_div_array.sv
div_result_stage.sv
approx_div_unit.sv
tb_approx_div_unit.sv

/* approx_div_unit.sv */
`timescale 1ns/100ps

module approx_div_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  approx_div_pkg::dividend_t  dividend,
  input  approx_div_pkg::divisor_t   divisor,
  output logic                       done,
  output approx_div_pkg::quotient_t  quotient,
  output approx_div_pkg::remainder_t remainder,
  output logic                       div_by_zero,
  output logic                       overflow
);

  logic                       cap_valid;
  approx_div_pkg::dividend_t  cap_dividend;
  approx_div_pkg::divisor_t   cap_divisor;
  logic                       cap_div_by_zero;
  logic                       cap_overflow;
  approx_div_pkg::quotient_t  arr_quotient;
  approx_div_pkg::remainder_t arr_remainder;

  // ############################################################
  // Capture, array, result register
  // ############################################################

  div_operand_capture u_capture (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .dividend        (dividend),
    .divisor         (divisor),
    .cap_valid       (cap_valid),
    .cap_dividend    (cap_dividend),
    .cap_divisor     (cap_divisor),
    .cap_div_by_zero (cap_div_by_zero),
    .cap_overflow    (cap_overflow)
  );

  approx_div_array u_array (
    .dividend  (cap_dividend),
    .divisor   (cap_divisor),
    .quotient  (arr_quotient),
    .remainder (arr_remainder)
  );

  div_result_stage u_result (
    .clk             (clk),
    .rst             (rst),
    .cap_valid       (cap_valid),
    .cap_dividend    (cap_dividend),
    .arr_quotient    (arr_quotient),
    .arr_remainder   (arr_remainder),
    .cap_div_by_zero (cap_div_by_zero),
    .cap_overflow    (cap_overflow),
    .done            (done),
    .quotient        (quotient),
    .remainder       (remainder),
    .div_by_zero     (div_by_zero),
    .overflow        (overflow)
  );

endmodule

/* div_operand_capture.sv */
`timescale 1ns/100ps

module div_operand_capture (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  approx_div_pkg::dividend_t dividend,
  input  approx_div_pkg::divisor_t  divisor,
  output logic                      cap_valid,
  output approx_div_pkg::dividend_t cap_dividend,
  output approx_div_pkg::divisor_t  cap_divisor,
  output logic                      cap_div_by_zero,
  output logic                      cap_overflow
);

  logic zero_divisor;
  logic quot_too_wide;

  // Flag conditions are decided here only, the result stage just carries them
  assign zero_divisor = (divisor == '0);

  // Upper dividend byte at or above the divisor means more than 8 quotient bits
  assign quot_too_wide = !zero_divisor &&
                         (dividend[$bits(dividend)-1 -: $bits(divisor)] >= divisor);

  // ############################################################
  // Control state
  // ############################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      cap_valid       <= 1'b0;
      cap_div_by_zero <= 1'b0;
      cap_overflow    <= 1'b0;
    end else begin
      cap_valid <= start;
      if (start) begin
        cap_div_by_zero <= zero_divisor;
        cap_overflow    <= quot_too_wide;
      end
    end
  end

  // ############################################################
  // Operand registers
  // ############################################################

  always_ff @(posedge clk) begin
    if (start) begin
      cap_dividend <= dividend;
      cap_divisor  <= divisor;
    end
  end

  // A zero divisor never counts as an overflow, so both flags cannot be set
  // for the same operation
  a_flags_exclusive : assert property (
    @(posedge clk) disable iff (rst)
    !(cap_div_by_zero && cap_overflow)
  );

endmodule

/* div_result_stage.sv */
`timescale 1ns/100ps
`include "approx_div_consts.svh"

module div_result_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cap_valid,
  input  approx_div_pkg::dividend_t  cap_dividend,
  input  approx_div_pkg::quotient_t  arr_quotient,
  input  approx_div_pkg::remainder_t arr_remainder,
  input  logic                       cap_div_by_zero,
  input  logic                       cap_overflow,
  output logic                       done,
  output approx_div_pkg::quotient_t  quotient,
  output approx_div_pkg::remainder_t remainder,
  output logic                       div_by_zero,
  output logic                       overflow
);

  localparam int D_W = `DIV_D_W;

  // ############################################################
  // Output register
  // ############################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      done        <= 1'b0;
      quotient    <= '0;
      remainder   <= '0;
      div_by_zero <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      done <= cap_valid;
      if (cap_valid) begin
        div_by_zero <= cap_div_by_zero;
        overflow    <= cap_overflow;
        if (cap_div_by_zero) begin
          // The array output is meaningless here, so return a fixed pattern
          quotient  <= '1;
          remainder <= cap_dividend[D_W-1:0];
        end else begin
          quotient  <= arr_quotient;
          remainder <= arr_remainder;
        end
      end
    end
  end

  // Back-to-back done pulses only come from back-to-back captures
  a_done_pair_from_capture : assert property (
    @(posedge clk) disable iff (rst)
    (done && $past(done)) |-> ($past(cap_valid, 1) && $past(cap_valid, 2))
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the approximate divider testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_approx_div_unit
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/100ps \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -f approx_div_unit.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build ended with status $status"
  exit "$status"
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0

/* tb_div_model.svh */
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

// ############################################################
// Reference model of the cell array
// ############################################################

// Rebuilds the divider row by row, returns {quotient, remainder}
function automatic logic [2*`DIV_D_W-1:0] model_divide(
  input approx_div_pkg::dividend_t n,
  input approx_div_pkg::divisor_t  d
);
  logic [`DIV_D_W-1:0]       part;
  logic [`DIV_D_W-1:0]       minuend;
  logic [`DIV_D_W:0]         wide_diff;
  logic                      spill;
  logic                      borrow;
  approx_div_pkg::quotient_t q;
  int                        row;
  q    = '0;
  part = '0;
  for (row = `DIV_D_W-1; row >= 0; row--) begin
    if (row == `DIV_D_W-1) begin
      minuend = n[`DIV_N_W-2 -: `DIV_D_W];
      spill   = n[`DIV_N_W-1];
    end else begin
      minuend = {part[`DIV_D_W-2:0], n[row]};
      spill   = part[`DIV_D_W-1];
    end
    if (row < `DIV_APPROX_ROWS) begin
      // Each cell hands its minuend bit on as borrow, so the last borrow is the top bit
      borrow = minuend[`DIV_D_W-1];
      q[row] = spill | ~borrow;
      part   = q[row] ? '0 : minuend;
    end else begin
      wide_diff = {1'b0, minuend} - {1'b0, d};
      borrow    = wide_diff[`DIV_D_W];
      q[row]    = spill | ~borrow;
      part      = q[row] ? wide_diff[`DIV_D_W-1:0] : minuend;
    end
  end
  return {q, part};
endfunction

// Xorshift32 stream
logic [31:0] rng_state = 32'd79;

function automatic logic [31:0] next_random();
  logic [31:0] s;
  s = rng_state;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  rng_state = s;
  return s;
endfunction

// ############################################################
// Compare tasks
// ############################################################

task automatic check_quotient(input string test, input approx_div_pkg::quotient_t expected,
                              input approx_div_pkg::quotient_t actual);
  if (actual !== expected) begin
    $display("** Error [%s] quotient: expected %h, actual %h", test, expected, actual);
    $display("Testbench failed");
    $fatal(1, "quotient mismatch");
  end
endtask

task automatic check_remainder(input string test, input approx_div_pkg::remainder_t expected,
                               input approx_div_pkg::remainder_t actual);
  if (actual !== expected) begin
    $display("** Error [%s] remainder: expected %h, actual %h", test, expected, actual);
    $display("Testbench failed");
    $fatal(1, "remainder mismatch");
  end
endtask

task automatic check_flag(input string test, input string flag, input logic expected,
                          input logic actual);
  if (actual !== expected) begin
    $display("** Error [%s] %s: expected %b, actual %b", test, flag, expected, actual);
    $display("Testbench failed");
    $fatal(1, "flag mismatch");
  end
endtask

`endif

/* tb_approx_div_unit.sv */
`timescale 1ns/100ps
`include "approx_div_consts.svh"

module tb_approx_div_unit;

  localparam int CLK_PERIOD = 4;
  localparam int DIRECTED_OPS = 8;
  localparam int STREAM_OPS = 300;
  localparam int EDGE_OPS = 8;
  localparam int GAPPED_OPS = 60;
  localparam int TOTAL_OPS = DIRECTED_OPS + STREAM_OPS + EDGE_OPS + GAPPED_OPS;
  localparam int WATCHDOG_CYCLES = (TOTAL_OPS + 20) * 3;
  localparam int DRAIN_LIMIT = 10;
  // Start is driven on one edge and done is first seen three edges later
  localparam int DONE_EDGES = 3;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       start;
  approx_div_pkg::dividend_t  dividend;
  approx_div_pkg::divisor_t   divisor;
  logic                       done;
  approx_div_pkg::quotient_t  quotient;
  approx_div_pkg::remainder_t remainder;
  logic                       div_by_zero;
  logic                       overflow;

  // Scoreboard with one entry per start
  string                      sb_name [$];
  approx_div_pkg::quotient_t  sb_quot [$];
  approx_div_pkg::remainder_t sb_rem [$];
  logic                       sb_dbz [$];
  logic                       sb_ovf [$];
  logic                       sb_data [$];
  int                         sb_cycle [$];
  int                         cycle_count = 0;

  `include "tb_div_model.svh"

  approx_div_unit DUT (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .dividend    (dividend),
    .divisor     (divisor),
    .done        (done),
    .quotient    (quotient),
    .remainder   (remainder),
    .div_by_zero (div_by_zero),
    .overflow    (overflow)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Testbench failed");
    $fatal(1, "timeout");
  end

  // ############################################################
  // Result monitor
  // ############################################################

  always @(posedge clk) begin
    string                      name;
    approx_div_pkg::quotient_t  exp_q;
    approx_div_pkg::remainder_t exp_r;
    logic                       exp_dbz;
    logic                       exp_ovf;
    logic                       exp_data;
    int                         issued;
    if (done === 1'b1) begin
      if (sb_name.size() == 0) begin
        $display("A done pulse arrived with no start waiting for it");
        $display("Testbench failed");
        $fatal(1, "unexpected done");
      end else begin
        name     = sb_name.pop_front();
        exp_q    = sb_quot.pop_front();
        exp_r    = sb_rem.pop_front();
        exp_dbz  = sb_dbz.pop_front();
        exp_ovf  = sb_ovf.pop_front();
        exp_data = sb_data.pop_front();
        issued   = sb_cycle.pop_front();
        if (cycle_count - issued != DONE_EDGES) begin
          $display("Done for %s came %0d cycles after start instead of 2",
                   name, cycle_count - issued - 1);
          $display("Testbench failed");
          $fatal(1, "wrong latency");
        end
        check_flag(name, "div_by_zero", exp_dbz, div_by_zero);
        check_flag(name, "overflow", exp_ovf, overflow);
        if (exp_data) begin
          check_quotient(name, exp_q, quotient);
          check_remainder(name, exp_r, remainder);
        end
      end
    end
  end

  // ############################################################
  // Drive helpers
  // ############################################################

  task automatic push_expected(input string name, input approx_div_pkg::dividend_t n,
                               input approx_div_pkg::divisor_t d);
    logic [2*`DIV_D_W-1:0]      model;
    logic                       dbz;
    logic                       ovf;
    approx_div_pkg::quotient_t  exp_q;
    approx_div_pkg::remainder_t exp_r;
    dbz = (d == '0);
    ovf = 1'b0;
    if (!dbz) begin
      // The true quotient no longer fits in one quotient word
      ovf = (int'(n) / int'(d)) >= (1 << `DIV_D_W);
    end
    model = model_divide(n, d);
    if (dbz) begin
      exp_q = '1;
      exp_r = n[`DIV_D_W-1:0];
    end else begin
      exp_q = model[2*`DIV_D_W-1 -: `DIV_D_W];
      exp_r = model[`DIV_D_W-1:0];
    end
    sb_name.push_back(name);
    sb_quot.push_back(exp_q);
    sb_rem.push_back(exp_r);
    sb_dbz.push_back(dbz);
    sb_ovf.push_back(ovf);
    sb_data.push_back(!ovf);
    sb_cycle.push_back(cycle_count);
  endtask

  task automatic issue_op(input string name, input approx_div_pkg::dividend_t n,
                          input approx_div_pkg::divisor_t d);
    @(posedge clk);
    start    <= 1'b1;
    dividend <= n;
    divisor  <= d;
    push_expected(name, n, d);
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      start <= 1'b0;
    end
  endtask

  task automatic wait_for_results(input string test);
    int waited;
    waited = 0;
    while (sb_name.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (sb_name.size() != 0) begin
      $display("%s: %0d results never arrived", test, sb_name.size());
      $display("Testbench failed");
      $fatal(1, "missing done");
    end
  endtask

  task automatic send_alone(input string name, input approx_div_pkg::dividend_t n,
                            input approx_div_pkg::divisor_t d);
    issue_op(name, n, d);
    go_idle(1);
    wait_for_results(name);
  endtask

  // Upper dividend byte is kept below the divisor
  task automatic random_pair(output approx_div_pkg::dividend_t n,
                             output approx_div_pkg::divisor_t d);
    logic [31:0]         r;
    logic [`DIV_D_W-1:0] hi;
    r = next_random();
    d = r[7:0];
    if (d == '0) begin
      d = 8'd1;
    end
    hi = r[15:8] % d;
    n  = {hi, r[23:16]};
  endtask

  task automatic check_idle_outputs(input string test);
    check_flag(test, "done", 1'b0, done);
    check_flag(test, "div_by_zero", 1'b0, div_by_zero);
    check_flag(test, "overflow", 1'b0, overflow);
    check_quotient(test, '0, quotient);
    check_remainder(test, '0, remainder);
  endtask

  // ############################################################
  // Tests
  // ############################################################

  task automatic test_reset();
    repeat (2) @(posedge clk);
    check_idle_outputs("reset");
    rst <= 1'b0;
    repeat (2) begin
      @(posedge clk);
      check_idle_outputs("after reset");
    end
  endtask

  task automatic test_directed();
    send_alone("directed", 16'd100, 8'd7);
    send_alone("directed", 16'd255, 8'd1);
    send_alone("directed", 16'd0, 8'd3);
    send_alone("directed", 16'd5, 8'd10);
    send_alone("directed", 16'd1000, 8'd9);
    send_alone("directed", 16'd12345, 8'd200);
    send_alone("directed", 16'h7fff, 8'h80);
    send_alone("directed", 16'hfeff, 8'hff);
  endtask

  task automatic test_stream();
    approx_div_pkg::dividend_t n;
    approx_div_pkg::divisor_t  d;
    for (int i = 0; i < STREAM_OPS; i++) begin
      random_pair(n, d);
      issue_op("stream", n, d);
    end
    go_idle(1);
    wait_for_results("stream");
  endtask

  task automatic test_flags();
    send_alone("div by zero", 16'h1234, 8'd0);
    send_alone("div by zero", 16'h0000, 8'd0);
    send_alone("div by zero", 16'hffff, 8'd0);
    send_alone("div by zero", 16'h00a5, 8'd0);
    send_alone("overflow", 16'h0500, 8'd5);
    send_alone("overflow", 16'hffff, 8'd1);
    send_alone("overflow", 16'h8000, 8'h80);
    send_alone("overflow", 16'hff00, 8'hff);
  endtask

  task automatic test_gapped();
    approx_div_pkg::dividend_t n;
    approx_div_pkg::divisor_t  d;
    logic [31:0]               r;
    int                        kind;
    for (int i = 0; i < GAPPED_OPS; i++) begin
      r    = next_random();
      kind = int'(r % 32'd3);
      if (kind == 0) begin
        random_pair(n, d);
      end else if (kind == 1) begin
        n = r[23:8];
        d = '0;
      end else begin
        // Divisor 1 to 128 against an upper byte of 128 or more
        d = {1'b0, r[6:0]} + 8'd1;
        n = {1'b1, r[14:8], r[23:16]};
      end
      issue_op("gapped", n, d);
      go_idle(int'(r[25:24]));
    end
    go_idle(1);
    wait_for_results("gapped");
  endtask

  initial begin
    rst      = 1'b1;
    start    = 1'b0;
    dividend = '0;
    divisor  = '0;
    test_reset();
    test_directed();
    test_stream();
    test_flags();
    test_gapped();
    // A stray done after the last result still reaches the monitor here
    go_idle(4);
    $display("Testbench passed");
    $finish;
  end

endmodule
